// ==== Makefile ====
# Verilator flow for the SPI link testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_link
RTL_TOP   ?= spi_link_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= design/spi_pkg.sv design/spi_master.sv design/spi_slave.sv design/spi_link_top.sv
TB_SRCS   ?= sim/tb_spi_link.sv

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/spi_link_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module spi_link_top #(
	parameter int DATA_WIDTH = 8,
	parameter int CLK_DIV    = 5
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  cpol,
	input  wire                  cpha,
	input  wire                  start,
	input  wire [DATA_WIDTH-1:0] master_tx_data,
	input  wire [DATA_WIDTH-1:0] slave_tx_data,
	output wire [DATA_WIDTH-1:0] master_rx_data,
	output wire                  done,
	output wire [DATA_WIDTH-1:0] slave_rx_data,
	output wire                  rx_valid,
	output wire                  busy,
	output wire                  sclk,
	output wire                  cs_n,
	output wire                  mosi,
	output wire                  miso
);

	// Bus wires double as monitor outputs
	spi_master #(
		.DATA_WIDTH (DATA_WIDTH),
		.CLK_DIV    (CLK_DIV)
	) spi_master_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.cpol    (cpol),
		.cpha    (cpha),
		.start   (start),
		.tx_data (master_tx_data),
		.miso    (miso),
		.sclk    (sclk),
		.cs_n    (cs_n),
		.mosi    (mosi),
		.busy    (busy),
		.done    (done),
		.rx_data (master_rx_data)
	);

	spi_slave #(
		.DATA_WIDTH (DATA_WIDTH)
	) spi_slave_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.cpol     (cpol),
		.cpha     (cpha),
		.tx_data  (slave_tx_data),
		.sclk     (sclk),
		.cs_n     (cs_n),
		.mosi     (mosi),
		.miso     (miso),
		.rx_data  (slave_rx_data),
		.rx_valid (rx_valid)
	);

endmodule

`default_nettype wire

// ==== design/spi_master.sv ====
`default_nettype none
`timescale 1ns/1ps

module spi_master import spi_pkg::*; #(
	parameter int DATA_WIDTH = 8,
	parameter int CLK_DIV    = 5
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   cpol,
	input  wire                   cpha,
	input  wire                   start,
	input  wire  [DATA_WIDTH-1:0] tx_data,
	input  wire                   miso,
	output logic                  sclk,
	output logic                  cs_n,
	output logic                  mosi,
	output logic                  busy,
	output logic                  done,
	output logic [DATA_WIDTH-1:0] rx_data
);

	localparam int CNT_W  = $clog2(CLK_DIV);
	localparam int EDGE_W = $clog2(2 * DATA_WIDTH);
	localparam logic [CNT_W-1:0]  CNT_LAST  = CNT_W'(CLK_DIV - 1);
	localparam logic [EDGE_W-1:0] EDGE_LAST = EDGE_W'(2 * DATA_WIDTH - 1);

	master_state_t         state;
	logic [CNT_W-1:0]      cnt;
	logic [EDGE_W-1:0]     edge_cnt;
	logic                  phase;
	logic [DATA_WIDTH-1:0] tx_shift;
	logic                  half_end;
	logic                  edge_now;
	logic                  leading;
	logic                  sample_en;
	logic                  shift_en;

	////////////////////////////////////////////////////////////
	// Half period timing and sequencing
	////////////////////////////////////////////////////////////

	assign half_end = (cnt == CNT_LAST);
	assign edge_now = (state == XFER) && half_end;

	// Phase 0 is the idle level, so a 0 to 1 toggle is a leading edge
	assign leading = ~phase;
	assign sclk    = cpol ^ phase;

	// cpha 0 samples on leading edges, cpha 1 on trailing edges
	assign sample_en = edge_now && (leading != cpha);
	// First edge never shifts, MSB is already on mosi from select fall
	assign shift_en  = edge_now && (leading == cpha) && (edge_cnt != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (state == IDLE || half_end) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			phase    <= 1'b0;
			edge_cnt <= '0;
			cs_n     <= 1'b1;
			busy     <= 1'b0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						state    <= LEAD;
						phase    <= 1'b0;
						edge_cnt <= '0;
						cs_n     <= 1'b0;
						busy     <= 1'b1;
					end
				end
				LEAD: begin
					if (half_end)
						state <= XFER;
				end
				XFER: begin
					if (half_end) begin
						phase    <= ~phase;
						edge_cnt <= edge_cnt + 1'b1;
						if (edge_cnt == EDGE_LAST)
							state <= TRAIL;
					end
				end
				TRAIL: begin
					// Hold time done, release the bus
					if (half_end) begin
						state <= IDLE;
						cs_n  <= 1'b1;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Shift registers, MSB first
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_shift <= '0;
		end else if (state == IDLE && start) begin
			tx_shift <= tx_data;
		end else if (shift_en) begin
			tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};
		end
	end

	assign mosi = tx_shift[DATA_WIDTH-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_data <= '0;
		end else if (sample_en) begin
			rx_data <= {rx_data[DATA_WIDTH-2:0], miso};
		end
	end

	// Slave needs two sync flops plus a detect cycle per sclk level
	a_clk_div_min: assert property (@(posedge clk) CLK_DIV >= 4)
		else $error("CLK_DIV must be at least 4");

	a_cs_low_in_xfer: assert property (@(posedge clk) disable iff (!rst_n)
		state == XFER |-> !cs_n)
		else $error("cs_n high during XFER");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done wider than one cycle");

endmodule

`default_nettype wire

// ==== design/spi_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// State types shared by the SPI master and slave
////////////////////////////////////////////////////////////

package spi_pkg;

	// Master sequencing through one word
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		LEAD  = 2'd1,
		XFER  = 2'd2,
		TRAIL = 2'd3
	} master_state_t;

	// Follows the synchronized select in the slave
	typedef enum logic [0:0] {
		S_IDLE   = 1'b0,
		S_ACTIVE = 1'b1
	} slave_state_t;

endpackage

`default_nettype wire

// ==== design/spi_slave.sv ====
`default_nettype none
`timescale 1ns/1ps

module spi_slave import spi_pkg::*; #(
	parameter int DATA_WIDTH = 8
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   cpol,
	input  wire                   cpha,
	input  wire  [DATA_WIDTH-1:0] tx_data,
	input  wire                   sclk,
	input  wire                   cs_n,
	input  wire                   mosi,
	output logic                  miso,
	output logic [DATA_WIDTH-1:0] rx_data,
	output logic                  rx_valid
);

	localparam int BIT_W = $clog2(DATA_WIDTH + 1);
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_WIDTH - 1);

	slave_state_t          state;
	logic                  sclk_s1;
	logic                  sclk_s2;
	logic                  sclk_d;
	logic                  cs_s1;
	logic                  cs_s2;
	logic                  mosi_s1;
	logic                  mosi_s2;
	logic                  cs_fall;
	logic                  sclk_edge;
	logic                  leading;
	logic                  sample_en;
	logic                  shift_en;
	logic [BIT_W-1:0]      bit_cnt;
	logic [DATA_WIDTH-1:0] tx_shift;
	logic [DATA_WIDTH-1:0] rx_shift;

	////////////////////////////////////////////////////////////
	// Bus synchronizers and edge detection
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sclk_s1 <= 1'b0;
			sclk_s2 <= 1'b0;
			sclk_d  <= 1'b0;
			cs_s1   <= 1'b1;
			cs_s2   <= 1'b1;
			mosi_s1 <= 1'b0;
			mosi_s2 <= 1'b0;
		end else begin
			sclk_s1 <= sclk;
			sclk_s2 <= sclk_s1;
			sclk_d  <= sclk_s2;
			cs_s1   <= cs_n;
			cs_s2   <= cs_s1;
			mosi_s1 <= mosi;
			mosi_s2 <= mosi_s1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= S_IDLE;
		else
			state <= cs_s2 ? S_IDLE : S_ACTIVE;
	end

	assign cs_fall   = (state == S_IDLE) && !cs_s2;
	assign sclk_edge = (state == S_ACTIVE) && (sclk_s2 != sclk_d);
	// Leaving the idle level set by cpol
	assign leading   = (sclk_d == cpol);

	assign sample_en = sclk_edge && (leading != cpha);
	// Skip the first shift in cpha 1 so the MSB is not lost
	assign shift_en  = sclk_edge && (leading == cpha) && (bit_cnt != '0);

	////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_shift <= '0;
		end else if (cs_fall) begin
			tx_shift <= tx_data;
		end else if (shift_en) begin
			tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};
		end
	end

	assign miso = (state == S_ACTIVE) ? tx_shift[DATA_WIDTH-1] : 1'b0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			rx_shift <= '0;
			rx_data  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= sample_en && (bit_cnt == BIT_LAST);
			if (state == S_IDLE) begin
				bit_cnt <= '0;
			end else if (sample_en) begin
				bit_cnt  <= bit_cnt + 1'b1;
				rx_shift <= {rx_shift[DATA_WIDTH-2:0], mosi_s2};
				// Last bit completes the word
				if (bit_cnt == BIT_LAST)
					rx_data <= {rx_shift[DATA_WIDTH-2:0], mosi_s2};
			end
		end
	end

	a_valid_in_select: assert property (@(posedge clk) disable iff (!rst_n)
		rx_valid |-> !cs_s2)
		else $error("rx_valid while select is high");

endmodule

`default_nettype wire

// ==== sim/tb_spi_link.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_spi_link;

	localparam int DATA_WIDTH = 8;
	localparam int CLK_DIV    = 5;
	localparam int CLK_PERIOD = 20;
	localparam int N_RANDOM   = 32;
	// Start to done in clk cycles
	localparam int LATENCY    = (2 * DATA_WIDTH + 2) * CLK_DIV + 1;
	localparam int TIMEOUT_NS = 40 * (LATENCY + 20) * CLK_PERIOD;

	logic                  clk;
	logic                  rst_n;
	logic                  cpol;
	logic                  cpha;
	logic                  start;
	logic [DATA_WIDTH-1:0] master_tx_data;
	logic [DATA_WIDTH-1:0] slave_tx_data;
	wire  [DATA_WIDTH-1:0] master_rx_data;
	wire                   done;
	wire  [DATA_WIDTH-1:0] slave_rx_data;
	wire                   rx_valid;
	wire                   busy;
	wire                   sclk;
	wire                   cs_n;
	wire                   mosi;
	wire                   miso;

	// Reference model and transfer bookkeeping
	logic [DATA_WIDTH-1:0] exp_master_rx = '0;
	logic [DATA_WIDTH-1:0] exp_slave_rx  = '0;
	logic                  in_flight     = 1'b0;
	logic                  sclk_prev     = 1'b0;
	int                    bit_idx       = 0;
	int                    rx_count      = 0;
	int                    n_issued      = 0;
	int                    n_accepted    = 0;
	int                    n_done        = 0;
	int                    n_ignored     = 0;
	integer                seed          = 1;

	logic [DATA_WIDTH-1:0] dir_m_words [4] = '{8'hA5, 8'h3C, 8'h81, 8'h7E};
	logic [DATA_WIDTH-1:0] dir_s_words [4] = '{8'h5A, 8'hC3, 8'h18, 8'hE7};

	spi_link_top #(
		.DATA_WIDTH (DATA_WIDTH),
		.CLK_DIV    (CLK_DIV)
	) spi_link_top_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.cpol           (cpol),
		.cpha           (cpha),
		.start          (start),
		.master_tx_data (master_tx_data),
		.slave_tx_data  (slave_tx_data),
		.master_rx_data (master_rx_data),
		.done           (done),
		.slave_rx_data  (slave_rx_data),
		.rx_valid       (rx_valid),
		.busy           (busy),
		.sclk           (sclk),
		.cs_n           (cs_n),
		.mosi           (mosi),
		.miso           (miso)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] got,
		input logic [DATA_WIDTH-1:0] expected);
		assert (got == expected)
		else report_failure($sformatf("MISMATCH %s: got 0x%h expected 0x%h",
			name, got, expected));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic expected);
		assert (got === expected)
		else report_failure($sformatf("MISMATCH %s: got 0x%h expected 0x%h",
			name, got, expected));
	endtask

	////////////////////////////////////////////////////////////
	// Bus and handshake checks
	////////////////////////////////////////////////////////////

	a_idle_bus: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> cs_n && (sclk == cpol))
		else report_failure("cs_n or sclk not at the idle level while busy is low");

	// Slave sees select rise three clocks late, miso follows it
	a_idle_miso: assert property (@(posedge clk) disable iff (!rst_n)
		(!busy && cs_n && $past(cs_n) && $past(cs_n, 2) && $past(cs_n, 3)) |-> !miso)
		else report_failure("miso not low on an idle bus");

	a_valid_in_xfer: assert property (@(posedge clk) disable iff (!rst_n)
		rx_valid |-> busy)
		else report_failure("rx_valid pulsed outside a transfer");

	always @(posedge clk) begin
		if (rst_n) begin
			if (done) begin
				assert (in_flight) else report_failure("done without an accepted start");
				assert (rx_count == 1)
				else report_failure($sformatf("MISMATCH rx_valid count: got 0x%h expected 0x1",
					rx_count));
				compare_word("master_rx_data", master_rx_data, exp_master_rx);
				in_flight = 1'b0;
				n_done++;
			end
			if (rx_valid) begin
				compare_word("slave_rx_data", slave_rx_data, exp_slave_rx);
				rx_count++;
			end
			// MSB first on both data lines at every sampling edge
			if (!cs_n && (sclk != sclk_prev) && ((sclk_prev == cpol) != cpha)) begin
				assert (bit_idx < DATA_WIDTH)
				else report_failure("More sampling edges than bits in one transfer");
				compare_bit("mosi", mosi, exp_slave_rx[DATA_WIDTH-1-bit_idx]);
				compare_bit("miso", miso, exp_master_rx[DATA_WIDTH-1-bit_idx]);
				bit_idx++;
			end
			// Words cross over, each side receives the other's
			if (start && !busy) begin
				exp_slave_rx  = master_tx_data;
				exp_master_rx = slave_tx_data;
				in_flight     = 1'b1;
				rx_count      = 0;
				bit_idx       = 0;
				n_accepted++;
			end else if (start) begin
				n_ignored++;
			end
			sclk_prev = sclk;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic wait_for_done();
		do @(posedge clk); while (!done);
	endtask

	task automatic pulse_start(input logic mode_cpol, input logic mode_cpha,
		input logic [DATA_WIDTH-1:0] m_word, input logic [DATA_WIDTH-1:0] s_word);
		@(negedge clk);
		cpol           = mode_cpol;
		cpha           = mode_cpha;
		master_tx_data = m_word;
		slave_tx_data  = s_word;
		start          = 1'b1;
		n_issued++;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic run_transfer(input logic mode_cpol, input logic mode_cpha,
		input logic [DATA_WIDTH-1:0] m_word, input logic [DATA_WIDTH-1:0] s_word);
		pulse_start(mode_cpol, mode_cpha, m_word, s_word);
		wait_for_done();
	endtask

	// Second start mid transfer with a new master word
	task automatic run_with_ignored_start(input logic [DATA_WIDTH-1:0] m_word,
		input logic [DATA_WIDTH-1:0] s_word);
		pulse_start(1'b1, 1'b1, m_word, s_word);
		repeat (10) @(negedge clk);
		master_tx_data = ~m_word;
		start          = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_for_done();
	endtask

	initial begin
		#(TIMEOUT_NS);
		report_failure("Watchdog timeout, a transfer never finished");
	end

	initial begin
		logic [31:0] rnd_mode;
		logic [31:0] rnd_m;
		logic [31:0] rnd_s;

		rst_n          = 1'b0;
		cpol           = 1'b0;
		cpha           = 1'b0;
		start          = 1'b0;
		master_tx_data = '0;
		slave_tx_data  = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		assert (!done && !rx_valid && !busy && cs_n && !miso && (sclk == cpol))
		else report_failure("Outputs not at their reset levels after reset");

		// One directed word pair per mode
		for (int mode = 0; mode < 4; mode++)
			run_transfer(mode[1], mode[0], dir_m_words[mode], dir_s_words[mode]);

		run_with_ignored_start(8'hC9, 8'h36);

		// Back to back, next start on the cycle after done
		for (int i = 0; i < N_RANDOM; i++) begin
			rnd_mode = $random(seed);
			rnd_m    = $random(seed);
			rnd_s    = $random(seed);
			run_transfer(rnd_mode[1], rnd_mode[0], rnd_m[DATA_WIDTH-1:0],
				rnd_s[DATA_WIDTH-1:0]);
		end

		repeat (5) @(negedge clk);
		if (n_accepted == n_issued && n_done == n_issued && n_ignored == 1) begin
			$display("Test passed");
			$finish;
		end else begin
			report_failure($sformatf("Wrong transfer count: %0d issued %0d accepted %0d done %0d ignored",
				n_issued, n_accepted, n_done, n_ignored));
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
design/spi_pkg.sv
design/spi_master.sv
design/spi_slave.sv
design/spi_link_top.sv
sim/tb_spi_link.sv
